// ==== flist.f ====
verilog/cache_bank_pkg.sv
verilog/cache_bank_array.sv
verilog/lru_age_tracker.sv
verilog/tag_lookup_stage.sv
verilog/miss_handler.sv
verilog/cache_bank_top.sv
testbench/cache_bank_mem_model.sv
testbench/cache_bank_tb.sv

// ==== Bender.yml ====
package:
  name: cache_bank

sources:
  - files:
      - verilog/cache_bank_pkg.sv
      - verilog/cache_bank_array.sv
      - verilog/lru_age_tracker.sv
      - verilog/tag_lookup_stage.sv
      - verilog/miss_handler.sv
      - verilog/cache_bank_top.sv
  - target: test
    files:
      - testbench/cache_bank_mem_model.sv
      - testbench/cache_bank_tb.sv

// ==== testbench/cache_bank_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_bank_tb;

  localparam int CLK_PERIOD       = 40;
  localparam int RESET_CYCLES     = 10;
  localparam int RANDOM_OPS       = 200;
  // directed accesses of the first four tests come ahead of the random run
  localparam int NUM_TRANSACTIONS = 8 + 3 + 6 + 10 + RANDOM_OPS;
  localparam int CYCLES_PER_TRANS = 400;

  logic                     CLK;
  logic                     nRST;
  logic                     cpu_req;
  cache_bank_pkg::cpu_req_t cpu_req_data;
  logic                     cpu_ack;
  cache_bank_pkg::word_t    cpu_rdata;
  logic                     mem_req;
  cache_bank_pkg::mem_req_t mem_req_data;
  logic                     mem_ack;
  cache_bank_pkg::word_t    mem_rdata;

  cache_bank_pkg::word_t    ref_mem [0:65535];
  logic                     expect_load;
  cache_bank_pkg::word_t    expected_rdata;
  logic                     ack_prev;
  logic                     mreq_prev;
  logic                     mack_prev;
  cache_bank_pkg::mem_req_t mdata_prev;
  logic [31:0]              rand_state;
  int                       checks;
  int                       errors;
  int                       test_err_base;

  cache_bank_top dut_i (
    .CLK, .nRST,
    .cpu_req, .cpu_req_data, .cpu_ack, .cpu_rdata,
    .mem_req, .mem_req_data, .mem_ack, .mem_rdata
  );

  cache_bank_mem_model mem_i (
    .CLK, .mem_req, .mem_req_data, .mem_ack, .mem_rdata
  );

  initial CLK = 1'b0;
  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cache_bank_pkg::word_t initial_word(input cache_bank_pkg::word_addr_t a);
    return {a ^ 16'h3c5a, ~a};
  endfunction

  function automatic cache_bank_pkg::word_addr_t block_word(input int tag, input int set,
                                                            input int off);
    return {cache_bank_pkg::tag_t'(tag), cache_bank_pkg::set_index_t'(set),
            cache_bank_pkg::block_offset_t'(off)};
  endfunction

  // a load returns the last value stored to the word, or its background value
  function automatic cache_bank_pkg::word_t reference_load(input cache_bank_pkg::word_addr_t a);
    return ref_mem[a];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] got);
    checks++;
    assert (got == expected) else begin
      $display("ERR %0t %s: expected %h, got %h", $time, name, expected, got);
      errors++;
    end
  endtask

  task automatic check_fetches(input cache_bank_pkg::word_addr_t a, input int expected);
    check_value($sformatf("fetch_count[%h]", a[15:2]), expected, mem_i.fetch_count[a[15:2]]);
  endtask

  // one four-phase transaction on the processor port
  task automatic cpu_access(input logic rw, input cache_bank_pkg::word_addr_t addr,
                            input cache_bank_pkg::word_t value);
    cpu_req_data.rw          = rw;
    cpu_req_data.addr        = addr;
    cpu_req_data.store_value = value;
    expect_load              = !rw;
    expected_rdata           = reference_load(addr);
    cpu_req                  = 1'b1;
    do @(negedge CLK); while (!cpu_ack);
    @(posedge CLK);
    #5;
    cpu_req = 1'b0;
    do @(negedge CLK); while (cpu_ack);
    @(posedge CLK);
    #5;
    if (rw) ref_mem[addr] = value;
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s, %0d errors", name, (errors == test_err_base) ? "ok" : "failed",
             errors - test_err_base);
    test_err_base = errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // comparison and port monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge CLK) begin
    if (cpu_ack && !ack_prev) begin
      assert (cpu_req) else begin
        $display("protocol failure at %0t: cpu_ack rose without a pending cpu_req", $time);
        errors++;
      end
      if (expect_load) begin
        check_value("cpu_rdata", expected_rdata, cpu_rdata);
      end
    end
    if (!cpu_ack && ack_prev) begin
      assert (!cpu_req) else begin
        $display("protocol failure at %0t: cpu_ack fell while cpu_req was still high", $time);
        errors++;
      end
    end
    ack_prev = cpu_ack;
  end

  always @(negedge CLK) begin
    if (nRST) begin
      if (mem_req && !mreq_prev) begin
        assert (!mack_prev) else begin
          $display("protocol failure at %0t: mem_req rose while mem_ack was still high", $time);
          errors++;
        end
      end
      if (!mem_req && mreq_prev) begin
        assert (mack_prev) else begin
          $display("protocol failure at %0t: mem_req fell before mem_ack came", $time);
          errors++;
        end
      end
      if (mem_req && mreq_prev) begin
        assert (mem_req_data.we == mdata_prev.we && mem_req_data.addr == mdata_prev.addr &&
                (!mem_req_data.we || mem_req_data.wdata == mdata_prev.wdata)) else begin
          $display("protocol failure at %0t: mem_req_data changed during a request", $time);
          errors++;
        end
      end
    end
    mreq_prev  = mem_req;
    mack_prev  = mem_ack;
    mdata_prev = mem_req_data;
  end

  initial begin
    #((RESET_CYCLES + NUM_TRANSACTIONS * CYCLES_PER_TRANS) * CLK_PERIOD);
    $display("watchdog expired at %0t, the bank stopped answering", $time);
    $display("TESTS FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int                         wb_base;
    logic                       op_store;
    cache_bank_pkg::word_addr_t op_addr;
    cpu_req        = 1'b0;
    cpu_req_data   = '0;
    nRST           = 1'b0;
    expect_load    = 1'b0;
    expected_rdata = '0;
    ack_prev       = 1'b0;
    mreq_prev      = 1'b0;
    mack_prev      = 1'b0;
    mdata_prev     = '0;
    checks         = 0;
    errors         = 0;
    test_err_base  = 0;
    rand_state     = 32'hdb0e47b0;
    for (int a = 0; a < 65536; a++) begin
      ref_mem[a] = initial_word(cache_bank_pkg::word_addr_t'(a));
    end
    repeat (RESET_CYCLES) @(posedge CLK);
    #5;
    nRST = 1'b1;

    // every set gets tag 1 in way 0, two words per block
    for (int s = 0; s < cache_bank_pkg::NUM_SETS; s++) begin
      cpu_access(1'b0, block_word(1, s, 0), '0);
      cpu_access(1'b0, block_word(1, s, 3), '0);
    end
    for (int s = 0; s < cache_bank_pkg::NUM_SETS; s++) begin
      check_fetches(block_word(1, s, 0), 1);
    end
    report_test("cold loads");

    cpu_access(1'b1, block_word(1, 1, 2), 32'hcafe_0001);
    cpu_access(1'b0, block_word(1, 1, 2), '0);
    cpu_access(1'b0, block_word(1, 1, 3), '0);
    check_fetches(block_word(1, 1, 0), 1);
    report_test("store then load");

    // A is tag 1, B tag 2 and C tag 3, all in set 2
    cpu_access(1'b0, block_word(1, 2, 0), '0);
    cpu_access(1'b0, block_word(2, 2, 1), '0);
    cpu_access(1'b0, block_word(1, 2, 2), '0);
    cpu_access(1'b0, block_word(3, 2, 3), '0);
    cpu_access(1'b0, block_word(1, 2, 1), '0);
    check_fetches(block_word(1, 2, 0), 1);
    cpu_access(1'b0, block_word(2, 2, 0), '0);
    check_fetches(block_word(2, 2, 0), 2);
    report_test("replacement");

    // block of tag 4 in set 3 goes dirty, then tag 5 pushes it out
    for (int i = 0; i < cache_bank_pkg::BLOCK_SIZE; i++) begin
      cpu_access(1'b1, block_word(4, 3, i), 32'h5100_0000 + i);
    end
    cpu_access(1'b0, block_word(1, 3, 1), '0);
    wb_base = mem_i.wb_count;
    cpu_access(1'b0, block_word(5, 3, 0), '0);
    check_value("wb_count", wb_base + cache_bank_pkg::BLOCK_SIZE, mem_i.wb_count);
    for (int i = 0; i < cache_bank_pkg::BLOCK_SIZE; i++) begin
      check_value("wb_addr", block_word(4, 3, i), mem_i.wb_addr[wb_base + i]);
      check_value("memory word", ref_mem[block_word(4, 3, i)],
                  mem_i.words[block_word(4, 3, i)]);
    end
    for (int i = 0; i < cache_bank_pkg::BLOCK_SIZE; i++) begin
      cpu_access(1'b0, block_word(4, 3, i), '0);
    end
    check_fetches(block_word(4, 3, 0), 2);
    report_test("write-back");

    for (int i = 0; i < RANDOM_OPS; i++) begin
      rand_state = lcg_next(rand_state);
      op_store   = rand_state[31];
      op_addr    = block_word(rand_state[30:28], rand_state[27:26], rand_state[25:24]);
      rand_state = lcg_next(rand_state);
      cpu_access(op_store, op_addr, rand_state);
    end
    report_test("random sequence");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cache_bank_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_bank_mem_model (
  input  logic                     CLK,
  input  logic                     mem_req,
  input  cache_bank_pkg::mem_req_t mem_req_data,
  output logic                     mem_ack,
  output cache_bank_pkg::word_t    mem_rdata
);

  localparam int LOG_DEPTH = 1024;

  cache_bank_pkg::word_t      words [0:65535];
  int                         fetch_count [0:16383];
  cache_bank_pkg::word_addr_t wb_addr [0:LOG_DEPTH-1];
  int                         wb_count;
  logic [31:0]                lcg_state;
  logic                       busy;
  logic [1:0]                 wait_left;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // background contents depend on every address bit
  function automatic cache_bank_pkg::word_t initial_word(input cache_bank_pkg::word_addr_t a);
    return {a ^ 16'h3c5a, ~a};
  endfunction

  initial begin
    mem_ack   = 1'b0;
    mem_rdata = '0;
    wb_count  = 0;
    busy      = 1'b0;
    wait_left = '0;
    lcg_state = 32'hdb0e47b0;
    for (int a = 0; a < 65536; a++) begin
      words[a] = initial_word(cache_bank_pkg::word_addr_t'(a));
    end
    for (int b = 0; b < 16384; b++) begin
      fetch_count[b] = 0;
    end
  end

  // each request waits zero to three cycles before the ack goes up
  always @(posedge CLK) begin
    #5;
    if (mem_ack) begin
      if (!mem_req) mem_ack = 1'b0;
    end else if (mem_req) begin
      if (!busy) begin
        busy      = 1'b1;
        lcg_state = lcg_next(lcg_state);
        wait_left = lcg_state[31:30];
      end
      if (wait_left != 0) begin
        wait_left = wait_left - 1'b1;
      end else begin
        busy = 1'b0;
        if (mem_req_data.we) begin
          words[mem_req_data.addr] = mem_req_data.wdata;
          if (wb_count < LOG_DEPTH) wb_addr[wb_count] = mem_req_data.addr;
          wb_count++;
        end else begin
          mem_rdata = words[mem_req_data.addr];
          // a block fetch always starts at offset zero
          if (mem_req_data.addr[1:0] == 2'b00) fetch_count[mem_req_data.addr[15:2]]++;
        end
        mem_ack = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_bank_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_bank_top (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     cpu_req,
  input  cache_bank_pkg::cpu_req_t cpu_req_data,
  output logic                     cpu_ack,
  output cache_bank_pkg::word_t    cpu_rdata,
  output logic                     mem_req,
  output cache_bank_pkg::mem_req_t mem_req_data,
  input  logic                     mem_ack,
  input  cache_bank_pkg::word_t    mem_rdata
);

  logic [cache_bank_pkg::NUM_WAYS-1:0]                  rd_valid;
  cache_bank_pkg::tag_t [cache_bank_pkg::NUM_WAYS-1:0]  rd_tag;
  cache_bank_pkg::word_t [cache_bank_pkg::NUM_WAYS-1:0] rd_word;
  logic                          victim_valid, victim_dirty;
  cache_bank_pkg::tag_t          victim_tag;
  cache_bank_pkg::word_t         victim_word;
  cache_bank_pkg::way_index_t    victim_way;
  cache_bank_pkg::set_index_t    query_set;
  logic                          word_we;
  cache_bank_pkg::set_index_t    word_set;
  cache_bank_pkg::way_index_t    word_way;
  cache_bank_pkg::block_offset_t word_offset;
  cache_bank_pkg::word_t         word_data;
  logic                          touch;
  cache_bank_pkg::set_index_t    touch_set;
  cache_bank_pkg::way_index_t    touch_way;
  cache_bank_pkg::lookup_t       lookup;
  logic                          lookup_valid, miss_done, touch_fill;
  logic                          fill_we;
  cache_bank_pkg::set_index_t    fill_set;
  cache_bank_pkg::way_index_t    fill_way;
  cache_bank_pkg::tag_t          fill_tag;
  cache_bank_pkg::block_offset_t fill_offset;
  cache_bank_pkg::word_t         fill_data;

  tag_lookup_stage lookup_i (.*);

  miss_handler miss_i (.*);

  // the replayed hit after a fill refreshes the filled way
  lru_age_tracker lru_i (
    .CLK, .nRST, .touch, .touch_set, .touch_way, .query_set,
    .valid_ways (rd_valid),
    .victim_way
  );

  cache_bank_array array_i (
    .CLK, .nRST,
    .rd_set    (query_set),
    .rd_way    (fill_way),
    .rd_offset (lookup.block_offset),
    .rd_valid, .rd_tag, .rd_word,
    .victim_valid, .victim_dirty, .victim_tag, .victim_word,
    .word_we, .word_set, .word_way, .word_offset, .word_data,
    .fill_we, .fill_set, .fill_way, .fill_offset, .fill_data,
    .set_valid (touch_fill),
    .valid_tag (fill_tag)
  );

endmodule

`default_nettype wire

// ==== verilog/miss_handler.sv ====
`timescale 1ns/100ps
`default_nettype none

module miss_handler (
  input  logic                          CLK,
  input  logic                          nRST,
  input  cache_bank_pkg::lookup_t       lookup,
  input  logic                          lookup_valid,
  input  cache_bank_pkg::way_index_t    victim_way,
  output cache_bank_pkg::set_index_t    query_set,
  input  logic                          victim_valid,
  input  logic                          victim_dirty,
  input  cache_bank_pkg::tag_t          victim_tag,
  input  cache_bank_pkg::word_t         victim_word,
  output logic                          mem_req,
  output cache_bank_pkg::mem_req_t      mem_req_data,
  input  logic                          mem_ack,
  input  cache_bank_pkg::word_t         mem_rdata,
  output logic                          fill_we,
  output cache_bank_pkg::set_index_t    fill_set,
  output cache_bank_pkg::way_index_t    fill_way,
  output cache_bank_pkg::tag_t          fill_tag,
  output cache_bank_pkg::block_offset_t fill_offset,
  output cache_bank_pkg::word_t         fill_data,
  output logic                          touch_fill,
  output logic                          miss_done
);

  cache_bank_pkg::miss_state_t   state;
  cache_bank_pkg::block_offset_t word_count;
  logic                          last_word;

  // MSHR contents
  cache_bank_pkg::set_index_t    mshr_set;
  cache_bank_pkg::tag_t          mshr_tag;
  cache_bank_pkg::way_index_t    mshr_way;

  assign last_word = (word_count ==
                      cache_bank_pkg::block_offset_t'(cache_bank_pkg::BLOCK_SIZE - 1));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine and memory handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= cache_bank_pkg::IDLE;
      mem_req    <= 1'b0;
      word_count <= '0;
    end else begin
      case (state)
        cache_bank_pkg::IDLE:
          if (lookup_valid && !lookup.hit) begin
            word_count <= '0;
            // only a line that holds newer data than memory is written back
            state <= (victim_valid && victim_dirty) ? cache_bank_pkg::VICTIM_EJECT
                                                    : cache_bank_pkg::BLOCK_PULL;
          end
        cache_bank_pkg::VICTIM_EJECT, cache_bank_pkg::BLOCK_PULL:
          if (mem_req) begin
            if (mem_ack) begin
              mem_req    <= 1'b0;
              word_count <= word_count + 1'b1;
              if (last_word) begin
                state <= (state == cache_bank_pkg::VICTIM_EJECT) ? cache_bank_pkg::BLOCK_PULL
                                                                  : cache_bank_pkg::FINISH;
              end
            end
          end else if (!mem_ack) begin
            // previous word fully retired, start the next one
            mem_req <= 1'b1;
          end
        cache_bank_pkg::FINISH:
          state <= cache_bank_pkg::IDLE;
        default:
          state <= cache_bank_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == cache_bank_pkg::IDLE && lookup_valid && !lookup.hit) begin
      mshr_set <= lookup.set_index;
      mshr_tag <= lookup.tag;
      mshr_way <= victim_way;
    end
  end

  // while idle the array and age tracker look at the set of the pending lookup
  assign query_set = (state == cache_bank_pkg::IDLE) ? lookup.set_index : mshr_set;

  assign mem_req_data.we    = (state == cache_bank_pkg::VICTIM_EJECT);
  assign mem_req_data.addr  = (state == cache_bank_pkg::VICTIM_EJECT) ?
                              {victim_tag, mshr_set, word_count} :
                              {mshr_tag, mshr_set, word_count};
  assign mem_req_data.wdata = victim_word;

  // the fill address also selects the victim word during write-back
  assign fill_we     = (state == cache_bank_pkg::BLOCK_PULL) && mem_req && mem_ack;
  assign fill_set    = mshr_set;
  assign fill_way    = (state == cache_bank_pkg::IDLE) ? victim_way : mshr_way;
  assign fill_tag    = mshr_tag;
  assign fill_offset = word_count;
  assign fill_data   = mem_rdata;

  assign touch_fill = (state == cache_bank_pkg::FINISH);
  assign miss_done  = (state == cache_bank_pkg::FINISH);

endmodule

`default_nettype wire

// ==== verilog/tag_lookup_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tag_lookup_stage (
  input  logic                                         CLK,
  input  logic                                         nRST,
  input  logic                                         cpu_req,
  input  cache_bank_pkg::cpu_req_t                     cpu_req_data,
  output logic                                         cpu_ack,
  output cache_bank_pkg::word_t                        cpu_rdata,
  input  logic [cache_bank_pkg::NUM_WAYS-1:0]          rd_valid,
  input  cache_bank_pkg::tag_t [cache_bank_pkg::NUM_WAYS-1:0]  rd_tag,
  input  cache_bank_pkg::word_t [cache_bank_pkg::NUM_WAYS-1:0] rd_word,
  output logic                                         word_we,
  output cache_bank_pkg::set_index_t                   word_set,
  output cache_bank_pkg::way_index_t                   word_way,
  output cache_bank_pkg::block_offset_t                word_offset,
  output cache_bank_pkg::word_t                        word_data,
  output logic                                         touch,
  output cache_bank_pkg::set_index_t                   touch_set,
  output cache_bank_pkg::way_index_t                   touch_way,
  output cache_bank_pkg::lookup_t                      lookup,
  output logic                                         lookup_valid,
  input  logic                                         miss_done
);

  typedef enum logic [2:0] {
    LK_IDLE,
    LK_COMPARE,
    LK_COMPLETE,
    LK_MISS_WAIT,
    LK_ACK
  } lookup_state_t;

  lookup_state_t                       state;
  logic [cache_bank_pkg::NUM_WAYS-1:0] hit_vec;
  logic                                hit_any;
  cache_bank_pkg::way_index_t          hit_way_c;

  // the array reads the set of the held request, so compare against every way
  always_comb begin
    hit_any   = 1'b0;
    hit_way_c = '0;
    for (int w = cache_bank_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = rd_valid[w] && (rd_tag[w] == lookup.tag);
      if (hit_vec[w]) begin
        hit_any   = 1'b1;
        hit_way_c = cache_bank_pkg::way_index_t'(w);
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state        <= LK_IDLE;
      cpu_ack      <= 1'b0;
      lookup_valid <= 1'b0;
    end else begin
      lookup_valid <= 1'b0;
      case (state)
        LK_IDLE:
          if (cpu_req) state <= LK_COMPARE;
        LK_COMPARE: begin
          state        <= hit_any ? LK_COMPLETE : LK_MISS_WAIT;
          lookup_valid <= !hit_any;
        end
        LK_COMPLETE: begin
          cpu_ack <= 1'b1;
          state   <= LK_ACK;
        end
        // the same request is compared again once the block is in
        LK_MISS_WAIT:
          if (miss_done) state <= LK_COMPARE;
        LK_ACK:
          if (!cpu_req) begin
            cpu_ack <= 1'b0;
            state   <= LK_IDLE;
          end
        default:
          state <= LK_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == LK_IDLE && cpu_req) begin
      lookup.req          <= cpu_req_data;
      lookup.block_offset <= cpu_req_data.addr[cache_bank_pkg::OFFSET_LEN-1:0];
      lookup.set_index    <= cpu_req_data.addr[cache_bank_pkg::OFFSET_LEN +:
                                               cache_bank_pkg::INDEX_LEN];
      lookup.tag          <= cpu_req_data.addr[cache_bank_pkg::ADDR_LEN-1 -:
                                               cache_bank_pkg::TAG_LEN];
    end
    if (state == LK_COMPARE) begin
      lookup.hit     <= hit_any;
      lookup.hit_way <= hit_way_c;
    end
    if (state == LK_COMPLETE) begin
      cpu_rdata <= lookup.req.rw ? lookup.req.store_value : rd_word[lookup.hit_way];
    end
  end

  // completion of a hit writes the store word and refreshes the way age
  assign word_we     = (state == LK_COMPLETE) && lookup.req.rw;
  assign word_set    = lookup.set_index;
  assign word_way    = lookup.hit_way;
  assign word_offset = lookup.block_offset;
  assign word_data   = lookup.req.store_value;

  assign touch     = (state == LK_COMPLETE);
  assign touch_set = lookup.set_index;
  assign touch_way = lookup.hit_way;

endmodule

`default_nettype wire

// ==== verilog/lru_age_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none

module lru_age_tracker (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                touch,
  input  cache_bank_pkg::set_index_t          touch_set,
  input  cache_bank_pkg::way_index_t          touch_way,
  input  cache_bank_pkg::set_index_t          query_set,
  input  logic [cache_bank_pkg::NUM_WAYS-1:0] valid_ways,
  output cache_bank_pkg::way_index_t          victim_way
);

  cache_bank_pkg::age_t ages [cache_bank_pkg::NUM_SETS][cache_bank_pkg::NUM_WAYS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int s = 0; s < cache_bank_pkg::NUM_SETS; s++) begin
        for (int w = 0; w < cache_bank_pkg::NUM_WAYS; w++) begin
          ages[s][w] <= '0;
        end
      end
    end else if (touch) begin
      for (int w = 0; w < cache_bank_pkg::NUM_WAYS; w++) begin
        if (cache_bank_pkg::way_index_t'(w) == touch_way) begin
          ages[touch_set][w] <= '0;
        end else if (ages[touch_set][w] != '1) begin
          ages[touch_set][w] <= ages[touch_set][w] + 1'b1;
        end
      end
    end
  end

  // an empty way wins outright, otherwise the oldest way with ties to the lowest index
  always_comb begin
    logic                 found_invalid;
    cache_bank_pkg::age_t oldest;
    found_invalid = 1'b0;
    oldest        = ages[query_set][0];
    victim_way    = '0;
    for (int w = 0; w < cache_bank_pkg::NUM_WAYS; w++) begin
      if (!found_invalid && !valid_ways[w]) begin
        found_invalid = 1'b1;
        victim_way    = cache_bank_pkg::way_index_t'(w);
      end else if (!found_invalid && (ages[query_set][w] > oldest)) begin
        oldest     = ages[query_set][w];
        victim_way = cache_bank_pkg::way_index_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_bank_array.sv ====
`timescale 1ns/100ps
`default_nettype none

module cache_bank_array (
  input  logic                                                 CLK,
  input  logic                                                 nRST,
  input  cache_bank_pkg::set_index_t                           rd_set,
  input  cache_bank_pkg::way_index_t                           rd_way,
  input  cache_bank_pkg::block_offset_t                        rd_offset,
  output logic [cache_bank_pkg::NUM_WAYS-1:0]                  rd_valid,
  output cache_bank_pkg::tag_t [cache_bank_pkg::NUM_WAYS-1:0]  rd_tag,
  output cache_bank_pkg::word_t [cache_bank_pkg::NUM_WAYS-1:0] rd_word,
  output logic                                                 victim_valid,
  output logic                                                 victim_dirty,
  output cache_bank_pkg::tag_t                                 victim_tag,
  output cache_bank_pkg::word_t                                victim_word,
  input  logic                                                 word_we,
  input  cache_bank_pkg::set_index_t                           word_set,
  input  cache_bank_pkg::way_index_t                           word_way,
  input  cache_bank_pkg::block_offset_t                        word_offset,
  input  cache_bank_pkg::word_t                                word_data,
  input  logic                                                 fill_we,
  input  cache_bank_pkg::set_index_t                           fill_set,
  input  cache_bank_pkg::way_index_t                           fill_way,
  input  cache_bank_pkg::block_offset_t                        fill_offset,
  input  cache_bank_pkg::word_t                                fill_data,
  input  logic                                                 set_valid,
  input  cache_bank_pkg::tag_t                                 valid_tag
);

  logic [cache_bank_pkg::NUM_SETS-1:0][cache_bank_pkg::NUM_WAYS-1:0] valid_q;
  logic [cache_bank_pkg::NUM_SETS-1:0][cache_bank_pkg::NUM_WAYS-1:0] dirty_q;
  cache_bank_pkg::tag_t  tag_q  [cache_bank_pkg::NUM_SETS][cache_bank_pkg::NUM_WAYS];
  cache_bank_pkg::word_t data_q [cache_bank_pkg::NUM_SETS][cache_bank_pkg::NUM_WAYS]
                                [cache_bank_pkg::BLOCK_SIZE];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (set_valid) begin
        valid_q[fill_set][fill_way] <= 1'b1;
        dirty_q[fill_set][fill_way] <= 1'b0;
      end
      if (word_we) dirty_q[word_set][word_way] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (word_we) data_q[word_set][word_way][word_offset] <= word_data;
    if (fill_we) data_q[fill_set][fill_way][fill_offset] <= fill_data;
    if (set_valid) tag_q[fill_set][fill_way] <= valid_tag;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int w = 0; w < cache_bank_pkg::NUM_WAYS; w++) begin
      rd_valid[w] = valid_q[rd_set][w];
      rd_tag[w]   = tag_q[rd_set][w];
      rd_word[w]  = data_q[rd_set][w][rd_offset];
    end
  end

  assign victim_valid = valid_q[rd_set][rd_way];
  assign victim_dirty = dirty_q[rd_set][rd_way];
  assign victim_tag   = tag_q[rd_set][rd_way];
  assign victim_word  = data_q[rd_set][rd_way][fill_offset];

endmodule

`default_nettype wire

// ==== verilog/cache_bank_pkg.sv ====
`default_nettype none

package cache_bank_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_SETS   = 4;
  localparam int NUM_WAYS   = 2;
  localparam int BLOCK_SIZE = 4;
  localparam int WORD_LEN   = 32;
  localparam int ADDR_LEN   = 16;

  // word address splits into tag, set index and block offset
  localparam int OFFSET_LEN = $clog2(BLOCK_SIZE);
  localparam int INDEX_LEN  = $clog2(NUM_SETS);
  localparam int TAG_LEN    = ADDR_LEN - INDEX_LEN - OFFSET_LEN;
  localparam int WAYS_LEN   = $clog2(NUM_WAYS);
  localparam int AGE_LEN    = 2;

  typedef logic [WORD_LEN-1:0]   word_t;
  typedef logic [ADDR_LEN-1:0]   word_addr_t;
  typedef logic [TAG_LEN-1:0]    tag_t;
  typedef logic [INDEX_LEN-1:0]  set_index_t;
  typedef logic [OFFSET_LEN-1:0] block_offset_t;
  typedef logic [WAYS_LEN-1:0]   way_index_t;
  typedef logic [AGE_LEN-1:0]    age_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // rw set means a store
  typedef struct packed {
    logic       rw;
    word_addr_t addr;
    word_t      store_value;
  } cpu_req_t;

  typedef struct packed {
    logic       we;
    word_addr_t addr;
    word_t      wdata;
  } mem_req_t;

  // request as held by the lookup stage, with its decoded fields
  typedef struct packed {
    cpu_req_t      req;
    set_index_t    set_index;
    tag_t          tag;
    block_offset_t block_offset;
    logic          hit;
    way_index_t    hit_way;
  } lookup_t;

  typedef enum logic [1:0] {
    IDLE,
    VICTIM_EJECT,
    BLOCK_PULL,
    FINISH
  } miss_state_t;

endpackage

`default_nettype wire
